//--- verilog/cachePkg.sv
package cachePkg;

  // data path and address widths
  localparam int unsigned XLEN = 64;
  localparam int unsigned AddrWidth = 32;

  // line geometry
  localparam int unsigned BeatsPerLine = 4;
  localparam int unsigned NumSets = 64;

  // address split
  localparam int unsigned OffsetWidth = 5;
  localparam int unsigned IndexWidth = 6;
  localparam int unsigned TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  // offset bits below the beat select
  localparam int unsigned ByteOffWidth = 3;
  localparam int unsigned BeatSelWidth = OffsetWidth - ByteOffWidth;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [XLEN-1:0] data_t;
  typedef logic [TagWidth-1:0] tag_t;
  typedef logic [IndexWidth-1:0] index_t;
  typedef logic [OffsetWidth-1:0] offset_t;
  typedef logic [BeatSelWidth-1:0] beat_t;

  // four doublewords, beat 0 in the low bits
  typedef data_t [BeatsPerLine-1:0] line_t;

  // byte address viewed as its fields
  typedef struct packed {
    tag_t tag;
    index_t index;
    offset_t offset;
  } addrFields_t;

  // memory read request, addr is 8-byte aligned
  typedef struct packed {
    logic valid;
    addr_t addr;
  } memReq_t;

  typedef struct packed {
    logic valid;
    data_t data;
  } memRsp_t;

  // beat number from the byte offset
  function automatic beat_t beatOf(offset_t offset);
    return offset[OffsetWidth-1 -: BeatSelWidth];
  endfunction

endpackage

//--- verilog/cacheWay.sv
`timescale 1ns/100ps

module cacheWay (
  input  logic              clk,
  input  logic              rst_n,
  // lookup side
  input  logic              lookupEn_i,
  input  cachePkg::index_t  lookupIdx_i,
  input  cachePkg::tag_t    cmpTag_i,
  input  cachePkg::offset_t cmpOffset_i,
  // fill side
  input  logic              fillEn_i,
  input  cachePkg::index_t  fillIdx_i,
  input  cachePkg::tag_t    fillTag_i,
  input  cachePkg::line_t   fillLine_i,
  // lookup result, one cycle after lookupEn_i
  output logic              hit_o,
  output cachePkg::data_t   word_o,
  output logic              valid_o
);
  import cachePkg::*;

  // storage arrays
  tag_t tagArr [NumSets];
  line_t dataArr [NumSets];
  logic [NumSets-1:0] validArr;

  // registered read of the looked-up set
  tag_t tagQ;
  line_t lineQ;
  logic validQ;

  // valid bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (fillEn_i) begin
      validArr[fillIdx_i] <= 1'b1;
    end
  end

  // tag and data written together on a fill
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillIdx_i] <= fillTag_i;
      dataArr[fillIdx_i] <= fillLine_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (lookupEn_i) begin
      validQ <= validArr[lookupIdx_i];
    end
  end

  // read registers hold until the next lookup
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ <= tagArr[lookupIdx_i];
      lineQ <= dataArr[lookupIdx_i];
    end
  end

  // compare against the tag latched by the controller
  assign hit_o = validQ && (tagQ == cmpTag_i);
  assign word_o = lineQ[beatOf(cmpOffset_i)];

  // victim choice needs the set's valid bit even on a miss
  assign valid_o = validQ;

  // a fill only happens while lookups are blocked, so the same set never collides
  fillLookupSameSet: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(fillEn_i && lookupEn_i && (fillIdx_i == lookupIdx_i))
  ) else $error("cacheWay: fill and lookup of set %0d in one cycle", fillIdx_i);

endmodule

//--- verilog/cacheCtrl.sv
`timescale 1ns/100ps

module cacheCtrl (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline port
  input  logic              reqValid_i,
  input  cachePkg::addr_t   reqAddr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output cachePkg::data_t   rdData_o,
  // lookup to both ways
  output logic              lookupEn_o,
  output cachePkg::index_t  lookupIdx_o,
  output cachePkg::tag_t    cmpTag_o,
  output cachePkg::offset_t cmpOffset_o,
  // way results
  input  logic              hit0_i,
  input  cachePkg::data_t   word0_i,
  input  logic              valid0_i,
  input  logic              hit1_i,
  input  cachePkg::data_t   word1_i,
  input  logic              valid1_i,
  // fill of the victim way
  output logic              fillEn0_o,
  output logic              fillEn1_o,
  output cachePkg::index_t  fillIdx_o,
  output cachePkg::tag_t    fillTag_o,
  output cachePkg::line_t   fillLine_o,
  // refill engine
  output logic              refillStart_o,
  output cachePkg::addr_t   refillAddr_o,
  input  logic              refillDone_i,
  input  cachePkg::line_t   refillLine_i
);
  import cachePkg::*;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    MISS,
    REFILL,
    RESPOND
  } state_t;

  state_t stateQ, stateD;
  addrFields_t reqFields, reqQ;
  logic anyHit;
  logic accept;
  logic victimQ, victimD;
  logic [NumSets-1:0] rrQ;

  assign reqFields = addrFields_t'(reqAddr_i);
  assign anyHit = hit0_i || hit1_i;

  // a hit in COMPARE frees the port for the next request
  assign addrOk_o = (stateQ == IDLE) || ((stateQ == COMPARE) && anyHit);
  assign accept = reqValid_i && addrOk_o;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE: begin
        if (reqValid_i) begin
          stateD = COMPARE;
        end
      end
      COMPARE: begin
        if (!anyHit) begin
          stateD = MISS;
        end else if (!reqValid_i) begin
          stateD = IDLE;
        end
      end
      MISS: stateD = REFILL;
      REFILL: begin
        if (refillDone_i) begin
          stateD = RESPOND;
        end
      end
      RESPOND: stateD = IDLE;
      default: stateD = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= IDLE;
    end else begin
      stateQ <= stateD;
    end
  end

  // accepted address, compared in the following cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= reqFields;
    end
  end

  assign lookupEn_o = accept;
  assign lookupIdx_o = reqFields.index;
  assign cmpTag_o = reqQ.tag;
  assign cmpOffset_o = reqQ.offset;

  // invalid way first, else the set's round-robin bit
  always_comb begin
    if (!valid0_i) begin
      victimD = 1'b0;
    end else if (!valid1_i) begin
      victimD = 1'b1;
    end else begin
      victimD = rrQ[reqQ.index];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimQ <= 1'b0;
      rrQ <= '0;
    end else begin
      if ((stateQ == COMPARE) && !anyHit) begin
        victimQ <= victimD;
      end
      // every refill of a set flips its bit
      if (stateQ == RESPOND) begin
        rrQ[reqQ.index] <= ~rrQ[reqQ.index];
      end
    end
  end

  assign dataOk_o = ((stateQ == COMPARE) && anyHit) || (stateQ == RESPOND);

  always_comb begin
    rdData_o = hit1_i ? word1_i : word0_i;
    if (stateQ == RESPOND) begin
      rdData_o = refillLine_i[beatOf(reqQ.offset)];
    end
  end

  // refilled line goes into the victim while it is returned
  assign fillEn0_o = (stateQ == RESPOND) && !victimQ;
  assign fillEn1_o = (stateQ == RESPOND) && victimQ;
  assign fillIdx_o = reqQ.index;
  assign fillTag_o = reqQ.tag;
  assign fillLine_o = refillLine_i;

  assign refillStart_o = (stateQ == MISS);
  assign refillAddr_o = {reqQ.tag, reqQ.index, {OffsetWidth{1'b0}}};

  // a tag never lives in both ways of a set
  hitsExclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(hit0_i && hit1_i)
  ) else $error("cacheCtrl: both ways hit for set %0d", reqQ.index);

endmodule

//--- verilog/refillUnit.sv
`timescale 1ns/100ps

module refillUnit #(
  parameter int unsigned MaxCredits = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  cachePkg::addr_t   lineAddr_i,
  output logic              done_o,
  output cachePkg::line_t   line_o,
  // memory port
  output cachePkg::memReq_t memReq_o,
  input  cachePkg::memRsp_t memRsp_i,
  input  logic              memCredit_i
);
  import cachePkg::*;

  // one spare bit so an overflow stays visible
  localparam int unsigned CreditWidth = $clog2(MaxCredits + 1) + 1;

  typedef logic [CreditWidth-1:0] credit_t;
  // counts 0 to BeatsPerLine
  typedef logic [BeatSelWidth:0] beatCnt_t;

  credit_t creditQ, creditD;
  beatCnt_t issueCntQ, rspCntQ;
  logic busyQ;
  logic issue;
  addr_t baseQ;
  line_t lineQ;

  assign issue = busyQ && (issueCntQ < BeatsPerLine) && (creditQ != '0);

  assign memReq_o.valid = issue;
  assign memReq_o.addr = {baseQ[AddrWidth-1:OffsetWidth], issueCntQ[BeatSelWidth-1:0],
                          {ByteOffWidth{1'b0}}};

  always_comb begin
    creditD = creditQ;
    if (issue) begin
      creditD = creditD - 1'b1;
    end
    if (memCredit_i) begin
      creditD = creditD + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      creditQ <= credit_t'(MaxCredits);
      busyQ <= 1'b0;
      issueCntQ <= '0;
      rspCntQ <= '0;
      done_o <= 1'b0;
    end else begin
      creditQ <= creditD;
      done_o <= 1'b0;
      if (start_i) begin
        busyQ <= 1'b1;
        issueCntQ <= '0;
        rspCntQ <= '0;
      end else if (busyQ) begin
        if (issue) begin
          issueCntQ <= issueCntQ + 1'b1;
        end
        if (memRsp_i.valid) begin
          rspCntQ <= rspCntQ + 1'b1;
          // last beat in, pulse done next cycle
          if (rspCntQ == beatCnt_t'(BeatsPerLine - 1)) begin
            busyQ <= 1'b0;
            done_o <= 1'b1;
          end
        end
      end
    end
  end

  // line base and beat slots
  always_ff @(posedge clk) begin
    if (start_i) begin
      baseQ <= lineAddr_i;
    end
    if (busyQ && memRsp_i.valid) begin
      lineQ[rspCntQ[BeatSelWidth-1:0]] <= memRsp_i.data;
    end
  end

  assign line_o = lineQ;

  creditBound: assert property (
    @(posedge clk) disable iff (!rst_n)
    creditQ <= MaxCredits
  ) else $error("refillUnit: credit count %0d above %0d", creditQ, MaxCredits);

  // responses only for requests already issued
  noStrayResponse: assert property (
    @(posedge clk) disable iff (!rst_n)
    memRsp_i.valid |-> (issueCntQ != rspCntQ)
  ) else $error("refillUnit: response with no request outstanding");

endmodule

//--- verilog/dcacheTop.sv
`timescale 1ns/100ps

module dcacheTop #(
  parameter int unsigned MaxCredits = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline port
  input  logic              reqValid_i,
  input  cachePkg::addr_t   reqAddr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output cachePkg::data_t   rdData_o,
  // memory port
  output cachePkg::memReq_t memReq_o,
  input  cachePkg::memRsp_t memRsp_i,
  input  logic              memCredit_i
);
  import cachePkg::*;

  // lookup broadcast
  logic lookupEn;
  index_t lookupIdx;
  tag_t cmpTag;
  offset_t cmpOffset;

  // per-way results
  logic hit0, hit1;
  logic valid0, valid1;
  data_t word0, word1;

  // fill path
  logic fillEn0, fillEn1;
  index_t fillIdx;
  tag_t fillTag;
  line_t fillLine;

  // refill handshake
  logic refillStart;
  logic refillDone;
  addr_t refillAddr;
  line_t refillLine;

  cacheWay way0 (
    .clk(clk), .rst_n(rst_n),
    .lookupEn_i(lookupEn), .lookupIdx_i(lookupIdx),
    .cmpTag_i(cmpTag), .cmpOffset_i(cmpOffset),
    .fillEn_i(fillEn0), .fillIdx_i(fillIdx), .fillTag_i(fillTag), .fillLine_i(fillLine),
    .hit_o(hit0), .word_o(word0), .valid_o(valid0)
  );

  cacheWay way1 (
    .clk(clk), .rst_n(rst_n),
    .lookupEn_i(lookupEn), .lookupIdx_i(lookupIdx),
    .cmpTag_i(cmpTag), .cmpOffset_i(cmpOffset),
    .fillEn_i(fillEn1), .fillIdx_i(fillIdx), .fillTag_i(fillTag), .fillLine_i(fillLine),
    .hit_o(hit1), .word_o(word1), .valid_o(valid1)
  );

  cacheCtrl ctrl (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .reqAddr_i(reqAddr_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
    .lookupEn_o(lookupEn), .lookupIdx_o(lookupIdx),
    .cmpTag_o(cmpTag), .cmpOffset_o(cmpOffset),
    .hit0_i(hit0), .word0_i(word0), .valid0_i(valid0),
    .hit1_i(hit1), .word1_i(word1), .valid1_i(valid1),
    .fillEn0_o(fillEn0), .fillEn1_o(fillEn1),
    .fillIdx_o(fillIdx), .fillTag_o(fillTag), .fillLine_o(fillLine),
    .refillStart_o(refillStart), .refillAddr_o(refillAddr),
    .refillDone_i(refillDone), .refillLine_i(refillLine)
  );

  refillUnit #(
    .MaxCredits(MaxCredits)
  ) refill (
    .clk(clk), .rst_n(rst_n),
    .start_i(refillStart), .lineAddr_i(refillAddr),
    .done_o(refillDone), .line_o(refillLine),
    .memReq_o(memReq_o), .memRsp_i(memRsp_i), .memCredit_i(memCredit_i)
  );

endmodule

//--- verification/memModel.sv
`timescale 1ns/100ps

module memModel #(
  parameter int unsigned MaxCredits = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  cachePkg::memReq_t memReq_i,
  output cachePkg::memRsp_t memRsp_o,
  output logic              memCredit_o,
  // sticky, set when more requests arrive than the queue holds
  output logic              overflow_o
);
  import cachePkg::*;

  integer seed;
  addr_t addrQ [$];
  int delayQ [$];
  addr_t popAddr;

  initial begin
    seed = 19;
    memRsp_o = '0;
    memCredit_o = 1'b0;
    overflow_o = 1'b0;
  end

  // driven on the falling edge, the cache samples on the rising one
  always @(negedge clk) begin
    memRsp_o = '0;
    memCredit_o = 1'b0;
    if (!rst_n) begin
      addrQ.delete();
      delayQ.delete();
    end else begin
      foreach (delayQ[i]) begin
        if (delayQ[i] > 0) begin
          delayQ[i]--;
        end
      end
      // responses leave strictly in request order
      if (delayQ.size() > 0 && delayQ[0] == 0) begin
        popAddr = addrQ.pop_front();
        void'(delayQ.pop_front());
        memRsp_o.valid = 1'b1;
        memRsp_o.data = {popAddr, ~popAddr};
        // entry left the queue, hand the credit back
        memCredit_o = 1'b1;
      end
      if (memReq_i.valid) begin
        if (addrQ.size() >= MaxCredits) begin
          overflow_o = 1'b1;
        end
        addrQ.push_back(memReq_i.addr);
        delayQ.push_back(1 + ($unsigned($random(seed)) % 6));
      end
    end
  end

endmodule

//--- verification/dcacheTb.sv
`timescale 1ns/100ps

// run once with MaxCredits = 2 and once with 3
module dcacheTb #(
  parameter int unsigned MaxCredits = 2
);
  import cachePkg::*;

  localparam int WaitLimit = 400;

  logic clk;
  logic rst_n;
  logic reqValid;
  addr_t reqAddr;
  logic addrOk;
  logic dataOk;
  data_t rdData;
  memReq_t memReq;
  memRsp_t memRsp;
  logic memCredit;
  logic memOverflow;

  // reads in acceptance order
  addr_t expAddrQ [$];
  logic expHitQ [$];
  int expCycleQ [$];
  addr_t reqLog [$];
  int cycleCnt = 0;
  integer seed;

  // expected contents of both ways
  tag_t modelTag [2][NumSets];
  logic modelValid [2][NumSets];
  logic modelRr [NumSets];

  dcacheTop #(.MaxCredits(MaxCredits)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqAddr_i(reqAddr),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .memReq_o(memReq), .memRsp_i(memRsp), .memCredit_i(memCredit)
  );

  memModel #(.MaxCredits(MaxCredits)) mem (
    .clk(clk), .rst_n(rst_n),
    .memReq_i(memReq), .memRsp_o(memRsp), .memCredit_o(memCredit),
    .overflow_o(memOverflow)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCnt++;
  end

  // memory rule, upper half is the aligned address, lower half its inverse
  function automatic data_t refWord(addr_t addr);
    addr_t aligned;
    aligned = {addr[31:3], 3'b000};
    return {aligned, ~aligned};
  endfunction

  // hit prediction, a miss also fills the model like a refill would
  function automatic logic modelAccess(addr_t addr);
    tag_t tag;
    index_t idx;
    int victim;
    tag = addr[31:11];
    idx = addr[10:5];
    for (int w = 0; w < 2; w++) begin
      if (modelValid[w][idx] && modelTag[w][idx] == tag) begin
        return 1'b1;
      end
    end
    if (!modelValid[0][idx]) begin
      victim = 0;
    end else if (!modelValid[1][idx]) begin
      victim = 1;
    end else begin
      victim = modelRr[idx];
    end
    modelValid[victim][idx] = 1'b1;
    modelTag[victim][idx] = tag;
    modelRr[idx] = ~modelRr[idx];
    return 1'b0;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // starts at a falling edge, returns at the falling edge after acceptance
  task automatic sendRead(input addr_t addr, output int stalls);
    stalls = 0;
    reqValid = 1'b1;
    reqAddr = addr;
    while (!addrOk) begin
      @(negedge clk);
      stalls++;
      if (stalls > WaitLimit) begin
        failRun($sformatf("timeout: read of 0x%h was never accepted", addr));
      end
    end
    expAddrQ.push_back(addr);
    expHitQ.push_back(modelAccess(addr));
    expCycleQ.push_back(cycleCnt);
    @(negedge clk);
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WaitLimit) begin
        failRun("timeout: a read never returned its data");
      end
    end while (expAddrQ.size() != 0);
    @(negedge clk);
  endtask

  // beat requests seen by memory
  always @(negedge clk) begin
    if (memReq.valid) begin
      reqLog.push_back(memReq.addr);
    end
  end

  // a hit returns one cycle after acceptance, a miss takes longer
  always @(negedge clk) begin
    if (memOverflow) begin
      failRun("memory request queue overflowed");
    end
    if (rst_n && dataOk) begin
      if (expAddrQ.size() == 0) begin
        failRun("dataOk raised with no read outstanding");
      end
      checkValue(rdData, refWord(expAddrQ[0]), $sformatf("data of 0x%h", expAddrQ[0]));
      checkValue((cycleCnt - expCycleQ[0]) == 1, expHitQ[0],
                 $sformatf("hit flag of 0x%h", expAddrQ[0]));
      void'(expAddrQ.pop_front());
      void'(expHitQ.pop_front());
      void'(expCycleQ.pop_front());
    end
  end

  initial begin
    int stalls;
    addr_t base;
    tag_t rTag;
    index_t rIdx;
    logic [1:0] rBeat;
    tag_t evictSeq [7];
    seed = 19;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqAddr = '0;
    for (int s = 0; s < NumSets; s++) begin
      modelValid[0][s] = 1'b0;
      modelValid[1][s] = 1'b0;
      modelRr[s] = 1'b0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    checkValue(addrOk, 1, "addrOk after reset");
    checkValue(dataOk, 0, "dataOk after reset");
    checkValue(memReq.valid, 0, "memory request valid after reset");

    // cold read fetches the four beats of one line
    base = 32'h0000_1000;
    reqLog.delete();
    sendRead(base + 8, stalls);
    reqValid = 1'b0;
    waitDrain();
    checkValue(reqLog.size(), 4, "beat requests for one line");
    for (int b = 0; b < 4; b++) begin
      checkValue(reqLog[b], base + 8 * b, $sformatf("address of beat %0d", b));
    end

    // rest of the line hits back to back
    for (int b = 0; b < 4; b++) begin
      if (b != 1) begin
        sendRead(base + 8 * b, stalls);
        checkValue(stalls, 0, "back-to-back hit acceptance");
      end
    end
    reqValid = 1'b0;
    waitDrain();

    // set 5: fill two ways, third tag evicts the first, kept tag still hits
    evictSeq = '{21'h10, 21'h11, 21'h10, 21'h11, 21'h12, 21'h11, 21'h10};
    foreach (evictSeq[i]) begin
      sendRead({evictSeq[i], 6'd5, 5'd16}, stalls);
    end
    reqValid = 1'b0;
    waitDrain();

    // random reads over 8 tags and 4 sets
    for (int n = 0; n < 200; n++) begin
      rTag = tag_t'(21'h40 + ($unsigned($random(seed)) % 8));
      rIdx = index_t'(8 + ($unsigned($random(seed)) % 4));
      rBeat = 2'($unsigned($random(seed)) % 4);
      sendRead({rTag, rIdx, rBeat, 3'b000}, stalls);
    end
    reqValid = 1'b0;
    waitDrain();

    if (memOverflow) begin
      failRun("memory request queue overflowed");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- filelist.f
verilog/cachePkg.sv
verilog/cacheWay.sv
verilog/cacheCtrl.sv
verilog/refillUnit.sv
verilog/dcacheTop.sv
verification/memModel.sv
verification/dcacheTb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  # package first, then the RTL bottom up
  - verilog/cachePkg.sv
  - verilog/cacheWay.sv
  - verilog/cacheCtrl.sv
  - verilog/refillUnit.sv
  - verilog/dcacheTop.sv
  - target: test
    files:
      - verification/memModel.sv
      - verification/dcacheTb.sv
